/* common/spritePkg.sv */
//--------------------------------------------------------------------------
// Tiles are square and tileSize must equal 2**tileLog2
// Only seven animation frames per row are addressable
//--------------------------------------------------------------------------
package spritePkg;

    // Screen coordinates and sprite corners
    localparam int coordWidth = 10;
    typedef logic [coordWidth-1:0] coord_t;

    // Sprite sheet addressing
    localparam int addrWidth = 20;
    typedef logic [addrWidth-1:0] sheetAddr_t;

    localparam int tileSize = 32;
    localparam int tileLog2 = 5;

    // Animation state values 0 to frameCount-1 select a column
    localparam int frameCount = 7;
    typedef logic [9:0] animState_t;

    //----------------------------------------------------------------------
    // Colour and layer types
    //----------------------------------------------------------------------
    typedef logic [7:0] colorChannel_t;

    // Hero wins over block, block over background
    typedef enum logic [1:0]
    {
        layerBackground = 2'd0,
        layerBlock      = 2'd1,
        layerKirby      = 2'd2
    } pixelLayer_t;

endpackage

/* rtl/palette/colorPalette.sv */
//--------------------------------------------------------------------------
// Reset clears every entry to black; read during a write gives old colour
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module colorPalette
#(
    parameter int indexWidth = 8
)
(
    input  logic                     Clk,
    input  logic                     arstN,
    input  logic                     paletteWrite,
    input  logic [indexWidth-1:0]    paletteWriteIndex,
    input  spritePkg::colorChannel_t paletteWriteRed,
    input  spritePkg::colorChannel_t paletteWriteGreen,
    input  spritePkg::colorChannel_t paletteWriteBlue,
    input  logic                     colorRead,
    input  logic [indexWidth-1:0]    colorIndex,
    output logic                     colorValid,
    output spritePkg::colorChannel_t red,
    output spritePkg::colorChannel_t green,
    output spritePkg::colorChannel_t blue
);

    import spritePkg::*;

    localparam int entryCount = 2 ** indexWidth;

    colorChannel_t redMem   [entryCount];
    colorChannel_t greenMem [entryCount];
    colorChannel_t blueMem  [entryCount];

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < entryCount; i++)
            begin
                redMem[i]   <= '0;
                greenMem[i] <= '0;
                blueMem[i]  <= '0;
            end
        end
        else if (paletteWrite)
        begin
            redMem[paletteWriteIndex]   <= paletteWriteRed;
            greenMem[paletteWriteIndex] <= paletteWriteGreen;
            blueMem[paletteWriteIndex]  <= paletteWriteBlue;
        end
    end

    //----------------------------------------------------------------------
    // Registered read port
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            colorValid <= 1'b0;
        else
            colorValid <= colorRead;
    end

    always_ff @(posedge Clk)
    begin
        if (colorRead)
        begin
            red   <= redMem[colorIndex];
            green <= greenMem[colorIndex];
            blue  <= blueMem[colorIndex];
        end
    end

endmodule

/* rtl/sprite/spriteAddress.sv */
//--------------------------------------------------------------------------
// One cycle latency, a new pixel may arrive every cycle
// Address wraps at 20 bits; frame row is always 0
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module spriteAddress
#(
    parameter int sheetWidthLog2 = 9
)
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   pixelValid,
    input  spritePkg::coord_t      drawX,
    input  spritePkg::coord_t      drawY,
    input  spritePkg::coord_t      kirbyX,
    input  spritePkg::coord_t      kirbyY,
    input  spritePkg::coord_t      blockX,
    input  spritePkg::coord_t      blockY,
    input  logic                   facingRight,
    input  spritePkg::animState_t  floatState,
    input  spritePkg::animState_t  walkState,
    input  spritePkg::animState_t  stillState,
    output logic                   addrValid,
    output spritePkg::sheetAddr_t  spriteAddr,
    output spritePkg::pixelLayer_t pixelLayer
);

    import spritePkg::*;

    localparam int                  frameBits = $clog2(frameCount);
    localparam logic [tileLog2-1:0] tileLast  = tileLog2'(tileSize - 1);

    logic                 kirbyHit;
    logic                 blockHit;
    logic [tileLog2-1:0]  kirbyDx;
    logic [tileLog2-1:0]  kirbyDy;
    logic [tileLog2-1:0]  blockDx;
    logic [tileLog2-1:0]  blockDy;
    logic [tileLog2-1:0]  kirbyOffX;
    logic [frameBits-1:0] frameCol;
    sheetAddr_t           kirbyAddr;
    sheetAddr_t           blockAddr;
    sheetAddr_t           backAddr;
    sheetAddr_t           nextAddr;
    pixelLayer_t          nextLayer;

    //----------------------------------------------------------------------
    // Hit tests
    //----------------------------------------------------------------------
    function automatic logic insideTile(input coord_t draw, input coord_t corner);
        logic [coordWidth:0] farEdge;
        // Extra bit keeps corners near the screen edge from wrapping
        farEdge = {1'b0, corner} + (coordWidth + 1)'(tileSize);
        return (draw >= corner) && ({1'b0, draw} < farEdge);
    endfunction

    assign kirbyHit = insideTile(drawX, kirbyX) && insideTile(drawY, kirbyY);
    assign blockHit = insideTile(drawX, blockX) && insideTile(drawY, blockY);

    // Inside a tile the offset fits in the low bits
    assign kirbyDx = drawX[tileLog2-1:0] - kirbyX[tileLog2-1:0];
    assign kirbyDy = drawY[tileLog2-1:0] - kirbyY[tileLog2-1:0];
    assign blockDx = drawX[tileLog2-1:0] - blockX[tileLog2-1:0];
    assign blockDy = drawY[tileLog2-1:0] - blockY[tileLog2-1:0];

    //----------------------------------------------------------------------
    // Frame column, first in-range state wins
    //----------------------------------------------------------------------
    function automatic logic [frameBits-1:0] pickFrame(input animState_t floatS,
                                                       input animState_t walkS,
                                                       input animState_t stillS);
        logic [frameBits-1:0] column;
        if (floatS < frameCount)
            column = floatS[frameBits-1:0];
        else if (walkS < frameCount)
            column = walkS[frameBits-1:0];
        else if (stillS < frameCount)
            column = stillS[frameBits-1:0];
        else
            column = '0;
        return column;
    endfunction

    assign frameCol = pickFrame(floatState, walkState, stillState);

    // Hero faces right in the sheet, block is stored mirrored
    assign kirbyOffX = facingRight ? kirbyDx : tileLast - kirbyDx;

    assign kirbyAddr = (sheetAddr_t'(frameCol) << tileLog2)
                     + (sheetAddr_t'(kirbyDy) << sheetWidthLog2)
                     + sheetAddr_t'(kirbyOffX);

    assign blockAddr = (sheetAddr_t'(blockDy) << sheetWidthLog2)
                     + sheetAddr_t'(tileLast - blockDx);

    assign backAddr  = (sheetAddr_t'(drawY) << sheetWidthLog2)
                     + sheetAddr_t'(drawX);

    always_comb
    begin
        if (kirbyHit)
        begin
            nextLayer = layerKirby;
            nextAddr  = kirbyAddr;
        end
        else if (blockHit)
        begin
            nextLayer = layerBlock;
            nextAddr  = blockAddr;
        end
        else
        begin
            nextLayer = layerBackground;
            nextAddr  = backAddr;
        end
    end

    //----------------------------------------------------------------------
    // Output register
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            addrValid <= 1'b0;
        else
            addrValid <= pixelValid;
    end

    always_ff @(posedge Clk)
    begin
        if (pixelValid)
        begin
            spriteAddr <= nextAddr;
            pixelLayer <= nextLayer;
        end
    end

endmodule

/* rtl/spriteRenderer.sv */
//--------------------------------------------------------------------------
// Address and palette paths are independent; outputs valid in strobe only
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module spriteRenderer
#(
    parameter int sheetWidthLog2 = 9,
    parameter int indexWidth     = 8
)
(
    input  logic                     Clk,
    input  logic                     arstN,
    // Pixel address path
    input  logic                     pixelValid,
    input  spritePkg::coord_t        drawX,
    input  spritePkg::coord_t        drawY,
    input  spritePkg::coord_t        kirbyX,
    input  spritePkg::coord_t        kirbyY,
    input  spritePkg::coord_t        blockX,
    input  spritePkg::coord_t        blockY,
    input  logic                     facingRight,
    input  spritePkg::animState_t    floatState,
    input  spritePkg::animState_t    walkState,
    input  spritePkg::animState_t    stillState,
    output logic                     addrValid,
    output spritePkg::sheetAddr_t    spriteAddr,
    output spritePkg::pixelLayer_t   pixelLayer,
    // Palette path
    input  logic                     paletteWrite,
    input  logic [indexWidth-1:0]    paletteWriteIndex,
    input  spritePkg::colorChannel_t paletteWriteRed,
    input  spritePkg::colorChannel_t paletteWriteGreen,
    input  spritePkg::colorChannel_t paletteWriteBlue,
    input  logic                     colorRead,
    input  logic [indexWidth-1:0]    colorIndex,
    output logic                     colorValid,
    output spritePkg::colorChannel_t red,
    output spritePkg::colorChannel_t green,
    output spritePkg::colorChannel_t blue
);

    spriteAddress
    #(
        .sheetWidthLog2 (sheetWidthLog2)
    )
    i_spriteAddress
    (
        .Clk         (Clk),
        .arstN       (arstN),
        .pixelValid  (pixelValid),
        .drawX       (drawX),
        .drawY       (drawY),
        .kirbyX      (kirbyX),
        .kirbyY      (kirbyY),
        .blockX      (blockX),
        .blockY      (blockY),
        .facingRight (facingRight),
        .floatState  (floatState),
        .walkState   (walkState),
        .stillState  (stillState),
        .addrValid   (addrValid),
        .spriteAddr  (spriteAddr),
        .pixelLayer  (pixelLayer)
    );

    colorPalette
    #(
        .indexWidth (indexWidth)
    )
    i_colorPalette
    (
        .Clk               (Clk),
        .arstN             (arstN),
        .paletteWrite      (paletteWrite),
        .paletteWriteIndex (paletteWriteIndex),
        .paletteWriteRed   (paletteWriteRed),
        .paletteWriteGreen (paletteWriteGreen),
        .paletteWriteBlue  (paletteWriteBlue),
        .colorRead         (colorRead),
        .colorIndex        (colorIndex),
        .colorValid        (colorValid),
        .red               (red),
        .green             (green),
        .blue              (blue)
    );

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the result
set -u

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log
simBinary=simRenderer

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module tbSpriteRenderer \
    -Mdir "$buildDir" \
    -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$logFile"; then
    echo "result: FAIL"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$logFile"; then
    echo "result: no closing result line in $logFile"
    exit 1
fi

echo "result: PASS"
exit 0

/* sim/renderCases.txt */
# Lines starting with # are comments; colours are hex, all other fields decimal
# 1 index red green blue : palette write
# 2 drawX drawY kirbyX kirbyY blockX blockY facingRight float walk still expAddr expLayer
# 3 index expRed expGreen expBlue : palette read
# 4 index newRed newGreen newBlue oldRed oldGreen oldBlue : read and write in one cycle
# Background outside both sprites
2 10 20 100 200 300 150 1 3 9 9 10250 0
2 639 479 100 200 300 150 1 3 9 9 245887 0
2 0 0 100 200 300 150 1 3 9 9 0 0
2 99 200 100 200 300 150 1 3 9 9 102499 0
# Hero facing right with edges
2 100 200 100 200 300 150 1 3 9 9 96 2
2 131 200 100 200 300 150 1 3 9 9 127 2
2 132 200 100 200 300 150 1 3 9 9 102532 0
2 110 231 100 200 300 150 1 3 9 9 15978 2
2 110 232 100 200 300 150 1 3 9 9 118894 0
# Hero facing left
2 110 205 100 200 300 150 0 3 9 9 2677 2
2 100 200 100 200 300 150 0 3 9 9 127 2
2 131 200 100 200 300 150 0 3 9 9 96 2
# Frame priority float then walk then still
2 105 210 100 200 300 150 1 6 0 0 5317 2
2 105 210 100 200 300 150 1 8 5 2 5285 2
2 105 210 100 200 300 150 1 7 10 6 5317 2
2 105 210 100 200 300 150 1 1023 1023 4 5253 2
2 105 210 100 200 300 150 1 100 7 7 5125 2
2 105 210 100 200 300 150 0 8 1 0 5178 2
# Block only, always mirrored
2 300 150 100 200 300 150 1 3 9 9 31 1
2 331 181 100 200 300 150 1 3 9 9 15872 1
2 310 160 100 200 300 150 1 3 9 9 5141 1
2 332 150 100 200 300 150 1 3 9 9 77132 0
2 300 182 100 200 300 150 1 3 9 9 93484 0
2 0 0 100 200 0 0 1 3 9 9 31 1
# Hero over block where they overlap
2 115 215 100 200 110 210 1 3 9 9 7791 2
2 115 215 100 200 110 210 0 3 9 9 7792 2
2 135 235 100 200 110 210 1 3 9 9 12806 1
2 109 209 100 200 110 210 1 3 9 9 4713 2
# Hero at the bottom right screen corner
2 639 479 620 460 300 150 1 2 9 9 9811 2
# Palette writes and reads
3 16 00 00 00
1 16 ff 00 80
3 16 ff 00 80
1 5 12 34 56
3 5 12 34 56
1 255 aa bb cc
3 255 aa bb cc
3 0 00 00 00
# Read during a write to the same index sees the old colour
4 5 77 88 99 12 34 56
3 5 77 88 99
4 9 01 02 03 00 00 00
3 9 01 02 03
1 16 3c 5a 7e
3 16 3c 5a 7e
# Pixel and palette traffic interleaved
2 20 30 100 200 300 150 1 3 9 9 15380 0
3 255 aa bb cc
2 120 220 100 200 300 150 1 3 9 9 10356 2

/* sim/spriteRenderer_assertions.sv */
//--------------------------------------------------------------------------
// Strobe timing checks, bound onto the renderer top level
// failCount holds the number of failed checks for the testbench verdict
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module spriteRenderer_assertions
(
    input logic Clk,
    input logic arstN,
    input logic pixelValid,
    input logic addrValid,
    input logic colorRead,
    input logic colorValid
);

    int failCount = 0;

    // Address strobe is the pixel strobe delayed by one cycle
    addrAfterPixel: assert property (@(posedge Clk) disable iff (!arstN)
                                     pixelValid |=> addrValid)
        else
        begin
            failCount++;
            $error("addrValid missing one cycle after pixelValid");
        end

    addrOnlyAfterPixel: assert property (@(posedge Clk) disable iff (!arstN)
                                         !pixelValid |=> !addrValid)
        else
        begin
            failCount++;
            $error("addrValid high without pixelValid one cycle earlier");
        end

    // Same rule on the palette read port
    colorAfterRead: assert property (@(posedge Clk) disable iff (!arstN)
                                     colorRead |=> colorValid)
        else
        begin
            failCount++;
            $error("colorValid missing one cycle after colorRead");
        end

    colorOnlyAfterRead: assert property (@(posedge Clk) disable iff (!arstN)
                                         !colorRead |=> !colorValid)
        else
        begin
            failCount++;
            $error("colorValid high without colorRead one cycle earlier");
        end

    quietInReset: assert property (@(posedge Clk) !arstN |-> (!addrValid && !colorValid))
        else
        begin
            failCount++;
            $error("valid strobe high while reset is asserted");
        end

endmodule

bind spriteRenderer spriteRenderer_assertions i_assertions
(
    .Clk        (Clk),
    .arstN      (arstN),
    .pixelValid (pixelValid),
    .addrValid  (addrValid),
    .colorRead  (colorRead),
    .colorValid (colorValid)
);

/* sim/tbSpriteRenderer.sv */
//--------------------------------------------------------------------------
// Runs the cases in sim/renderCases.txt from the project root, then random
// back-to-back background pixels; results are checked at the falling edge
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tbSpriteRenderer;

    import spritePkg::*;

    localparam int    sheetWidthLog2 = 9;
    localparam int    indexWidth     = 8;
    localparam int    clkPeriod      = 40;
    localparam int    resetCycles    = 5;
    localparam int    randomPixels   = 40;
    localparam int    drainLimit     = 50;
    localparam string caseFile       = "sim/renderCases.txt";

    logic                  Clk;
    logic                  arstN;
    logic                  pixelValid;
    coord_t                drawX;
    coord_t                drawY;
    coord_t                kirbyX;
    coord_t                kirbyY;
    coord_t                blockX;
    coord_t                blockY;
    logic                  facingRight;
    animState_t            floatState;
    animState_t            walkState;
    animState_t            stillState;
    logic                  addrValid;
    sheetAddr_t            spriteAddr;
    pixelLayer_t           pixelLayer;
    logic                  paletteWrite;
    logic [indexWidth-1:0] paletteWriteIndex;
    colorChannel_t         paletteWriteRed;
    colorChannel_t         paletteWriteGreen;
    colorChannel_t         paletteWriteBlue;
    logic                  colorRead;
    logic [indexWidth-1:0] colorIndex;
    logic                  colorValid;
    colorChannel_t         red;
    colorChannel_t         green;
    colorChannel_t         blue;

    int          errorCount;
    int          pixelChecks;
    int          colorChecks;
    bit          timedOut;
    bit          setupFailed;
    logic [31:0] randState;

    // Expected results in issue order as {address, layer} and {r, g, b}
    logic [21:0] pixelExpect [$];
    logic [23:0] colorExpect [$];

    spriteRenderer
    #(
        .sheetWidthLog2 (sheetWidthLog2),
        .indexWidth     (indexWidth)
    )
    i_dut
    (
        .Clk               (Clk),
        .arstN             (arstN),
        .pixelValid        (pixelValid),
        .drawX             (drawX),
        .drawY             (drawY),
        .kirbyX            (kirbyX),
        .kirbyY            (kirbyY),
        .blockX            (blockX),
        .blockY            (blockY),
        .facingRight       (facingRight),
        .floatState        (floatState),
        .walkState         (walkState),
        .stillState        (stillState),
        .addrValid         (addrValid),
        .spriteAddr        (spriteAddr),
        .pixelLayer        (pixelLayer),
        .paletteWrite      (paletteWrite),
        .paletteWriteIndex (paletteWriteIndex),
        .paletteWriteRed   (paletteWriteRed),
        .paletteWriteGreen (paletteWriteGreen),
        .paletteWriteBlue  (paletteWriteBlue),
        .colorRead         (colorRead),
        .colorIndex        (colorIndex),
        .colorValid        (colorValid),
        .red               (red),
        .green             (green),
        .blue              (blue)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] next;
        next = state;
        next = next ^ (next << 13);
        next = next ^ (next >> 17);
        next = next ^ (next << 5);
        return next;
    endfunction

    //----------------------------------------------------------------------
    // Stimulus with one operation per rising edge
    //----------------------------------------------------------------------
    task automatic driveIdle();
        @(posedge Clk);
        pixelValid   <= 1'b0;
        paletteWrite <= 1'b0;
        colorRead    <= 1'b0;
    endtask

    task automatic drivePixel(input int px, input int py, input int kx, input int ky,
                              input int bx, input int by, input bit facing,
                              input int floatS, input int walkS, input int stillS,
                              input int expAddr, input int expLayer);
        @(posedge Clk);
        pixelValid   <= 1'b1;
        paletteWrite <= 1'b0;
        colorRead    <= 1'b0;
        drawX        <= coord_t'(px);
        drawY        <= coord_t'(py);
        kirbyX       <= coord_t'(kx);
        kirbyY       <= coord_t'(ky);
        blockX       <= coord_t'(bx);
        blockY       <= coord_t'(by);
        facingRight  <= facing;
        floatState   <= animState_t'(floatS);
        walkState    <= animState_t'(walkS);
        stillState   <= animState_t'(stillS);
        pixelExpect.push_back({sheetAddr_t'(expAddr), 2'(expLayer)});
    endtask

    task automatic drivePalette(input bit doWrite, input int writeIndex,
                                input logic [23:0] writeColor, input bit doRead,
                                input int readIndex, input logic [23:0] expColor);
        @(posedge Clk);
        pixelValid        <= 1'b0;
        paletteWrite      <= doWrite;
        paletteWriteIndex <= indexWidth'(writeIndex);
        paletteWriteRed   <= writeColor[23:16];
        paletteWriteGreen <= writeColor[15:8];
        paletteWriteBlue  <= writeColor[7:0];
        colorRead         <= doRead;
        colorIndex        <= indexWidth'(readIndex);
        if (doRead)
            colorExpect.push_back(expColor);
    endtask

    task automatic waitDrained(input string what);
        int cycles;
        cycles = 0;
        driveIdle();
        while ((pixelExpect.size() != 0 || colorExpect.size() != 0) && cycles < drainLimit)
        begin
            @(posedge Clk);
            cycles++;
        end
        if (pixelExpect.size() != 0 || colorExpect.size() != 0)
        begin
            $display("timeout: %s results did not arrive within %0d cycles", what, drainLimit);
            timedOut = 1'b1;
        end
    endtask

    task automatic runCaseLine(input string text, input int lineNo);
        int op, got;
        int px, py, kx, ky, bx, by, facing, floatS, walkS, stillS, expAddr, expLayer;
        int idx, r, g, b, oldR, oldG, oldB;
        got = $sscanf(text, "%d", op);
        if (got == 1)
        begin
            case (op)
                1: got = $sscanf(text, "%d %d %h %h %h", op, idx, r, g, b) - 5;
                2: got = $sscanf(text, "%d %d %d %d %d %d %d %d %d %d %d %d %d", op, px, py,
                                 kx, ky, bx, by, facing, floatS, walkS, stillS, expAddr,
                                 expLayer) - 13;
                3: got = $sscanf(text, "%d %d %h %h %h", op, idx, r, g, b) - 5;
                4: got = $sscanf(text, "%d %d %h %h %h %h %h %h", op, idx, r, g, b,
                                 oldR, oldG, oldB) - 8;
                default: got = -1;
            endcase
            if (got != 0)
            begin
                $display("case file line %0d could not be understood", lineNo);
                errorCount++;
            end
            else if (op == 1)
                drivePalette(1'b1, idx, {8'(r), 8'(g), 8'(b)}, 1'b0, 0, 24'h0);
            else if (op == 2)
                drivePixel(px, py, kx, ky, bx, by, facing[0], floatS, walkS, stillS,
                           expAddr, expLayer);
            else if (op == 3)
                drivePalette(1'b0, 0, 24'h0, 1'b1, idx, {8'(r), 8'(g), 8'(b)});
            else
                drivePalette(1'b1, idx, {8'(r), 8'(g), 8'(b)}, 1'b1, idx,
                             {8'(oldR), 8'(oldG), 8'(oldB)});
        end
    endtask

    task automatic runCaseFile();
        int    fd;
        int    got;
        int    lineNo;
        string lineText;
        fd = $fopen(caseFile, "r");
        if (fd == 0)
        begin
            $display("could not open the case file %s", caseFile);
            setupFailed = 1'b1;
        end
        else
        begin
            lineNo = 0;
            while (!$feof(fd))
            begin
                lineText = "";
                got = $fgets(lineText, fd);
                lineNo++;
                if (got > 0)
                    runCaseLine(lineText, lineNo);
            end
            $fclose(fd);
            waitDrained("case file");
        end
    endtask

    // Sprites sit in the top rows, so rows from 64 down are background
    task automatic runRandomPixels();
        int px;
        int py;
        for (int n = 0; n < randomPixels; n++)
        begin
            randState = xorshift32(randState);
            px = int'(randState % 32'd640);
            randState = xorshift32(randState);
            py = 64 + int'(randState % 32'd416);
            drivePixel(px, py, 0, 0, 32, 0, 1'b1, 0, 0, 0,
                       py * (1 << sheetWidthLog2) + px, int'(layerBackground));
        end
        waitDrained("random pixel");
    endtask

    //----------------------------------------------------------------------
    // Result checks
    //----------------------------------------------------------------------
    always @(negedge Clk)
    begin
        logic [21:0] expPixel;
        logic [23:0] expColor;
        if (addrValid === 1'b1)
        begin
            if (pixelExpect.size() == 0)
            begin
                $display("addrValid went high at %0t with no pixel pending", $time);
                errorCount++;
            end
            else
            begin
                expPixel = pixelExpect.pop_front();
                pixelChecks++;
                assert (spriteAddr === expPixel[21:2] && pixelLayer === expPixel[1:0])
                else
                begin
                    errorCount++;
                    $display("error %0t: address %0d layer %0d, expected %0d layer %0d",
                             $time, spriteAddr, pixelLayer, expPixel[21:2], expPixel[1:0]);
                end
            end
        end
        if (colorValid === 1'b1)
        begin
            if (colorExpect.size() == 0)
            begin
                $display("colorValid went high at %0t with no read pending", $time);
                errorCount++;
            end
            else
            begin
                expColor = colorExpect.pop_front();
                colorChecks++;
                assert ({red, green, blue} === expColor)
                else
                begin
                    errorCount++;
                    $display("error %0t: colour %h %h %h, expected %h %h %h", $time,
                             red, green, blue, expColor[23:16], expColor[15:8],
                             expColor[7:0]);
                end
            end
        end
    end

    initial
    begin
        arstN             = 1'b0;
        pixelValid        = 1'b0;
        drawX             = '0;
        drawY             = '0;
        kirbyX            = '0;
        kirbyY            = '0;
        blockX            = '0;
        blockY            = '0;
        facingRight       = 1'b1;
        floatState        = '0;
        walkState         = '0;
        stillState        = '0;
        paletteWrite      = 1'b0;
        paletteWriteIndex = '0;
        paletteWriteRed   = '0;
        paletteWriteGreen = '0;
        paletteWriteBlue  = '0;
        colorRead         = 1'b0;
        colorIndex        = '0;
        errorCount        = 0;
        pixelChecks       = 0;
        colorChecks       = 0;
        timedOut          = 1'b0;
        setupFailed       = 1'b0;
        randState         = 32'd73490;

        repeat (resetCycles) @(posedge Clk);
        arstN <= 1'b1;

        // No strobe may appear before the first request
        repeat (3)
        begin
            @(negedge Clk);
            assert (addrValid === 1'b0 && colorValid === 1'b0)
            else
            begin
                errorCount++;
                $display("error %0t: a valid strobe is high before any request", $time);
            end
        end

        // Every entry is black straight after reset
        for (int i = 0; i < (1 << indexWidth); i++)
            drivePalette(1'b0, 0, 24'h0, 1'b1, i, 24'h0);
        waitDrained("palette sweep");

        if (!timedOut)
            runCaseFile();
        if (!timedOut && !setupFailed)
            runRandomPixels();

        $display("pixel checks %0d, colour checks %0d, errors %0d, assertion failures %0d",
                 pixelChecks, colorChecks, errorCount, i_dut.i_assertions.failCount);
        if (errorCount == 0 && i_dut.i_assertions.failCount == 0 && !timedOut
            && !setupFailed)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb.f */
common/spritePkg.sv
rtl/sprite/spriteAddress.sv
rtl/palette/colorPalette.sv
rtl/spriteRenderer.sv
sim/spriteRenderer_assertions.sv
sim/tbSpriteRenderer.sv
